/* Makefile */
# Verilator simulation of the load/store unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module ls_unit_tb \
		-Mdir obj_dir -o ls_unit_sim
	./obj_dir/ls_unit_sim

clean:
	rm -rf obj_dir

/* include/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath width, shared by data and addresses
`define MIPS_DATA_W 32

// Register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_W 5

// Data memory geometry, word addressed by the low address bits
`define DMEM_DEPTH 32
`define DMEM_ADDR_W 5

`endif

/* tb/ls_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_unit_assertions (
    input wire logic i_clock,
    input wire logic i_arst_n,
    input wire logic i_instr_valid,
    input wire logic i_wb_valid,
    input wire logic i_illegal,
    input wire logic i_memread,
    input wire logic i_memwrite
);

    // A result always traces back to a strobe two edges earlier
    wb_has_strobe: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_wb_valid |-> $past(i_instr_valid, 2)
    ) else $error("writeback pulse without a matching instruction strobe");

    // One memory request per cycle
    mem_one_strobe: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        !(i_memread && i_memwrite)
    ) else $error("memory read and write strobes high together");

    // An illegal slot never produces a result one cycle later
    illegal_no_result: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_illegal |=> !i_wb_valid
    ) else $error("illegal opcode produced a writeback");

endmodule

bind ls_unit_top ls_unit_assertions u_assertions (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_instr_valid (i_instr_valid),
    .i_wb_valid    (o_wb_valid),
    .i_illegal     (o_illegal),
    .i_memread     (m_memread),
    .i_memwrite    (m_memwrite)
);

`default_nettype wire

/* tb/ls_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module ls_unit_tb;

    // About 240 cycles of tests plus margin
    localparam int TIMEOUT_CYCLES = 400;

    logic                        i_clock;
    logic                        i_arst_n;
    logic                        i_instr_valid;
    logic [`MIPS_DATA_W-1:0]     i_instr;
    logic [`MIPS_REG_ADDR_W-1:0] i_dbg_reg;
    logic                        o_wb_valid;
    logic [`MIPS_REG_ADDR_W-1:0] o_wb_rd;
    logic [`MIPS_DATA_W-1:0]     o_wb_data;
    logic                        o_illegal;
    logic [`MIPS_DATA_W-1:0]     o_dbg_data;

    // Reference model state
    logic [`MIPS_DATA_W-1:0] model_regs [`MIPS_REG_COUNT];
    logic [`MIPS_DATA_W-1:0] model_mem  [`DMEM_DEPTH];
    logic [31:0]             lcg_state = 32'h50a7_d166;
    int                      cycle_count = 0;

    ls_unit_top u_ls_unit_top (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_dbg_reg     (i_dbg_reg),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_illegal     (o_illegal),
        .o_dbg_data    (o_dbg_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] make_instr(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] load_extend(input mips_pkg::opcode_e op,
                                                input logic [31:0] word);
        case (op)
            mips_pkg::OP_LB:  return {{24{word[7]}}, word[7:0]};
            mips_pkg::OP_LBU: return {24'd0, word[7:0]};
            mips_pkg::OP_LH:  return sext16(word[15:0]);
            mips_pkg::OP_LHU: return {16'd0, word[15:0]};
            default:          return word;
        endcase
    endfunction

    // Narrow stores clear the rest of the word
    function automatic logic [31:0] store_fill(input mips_pkg::opcode_e op,
                                               input logic [31:0] data);
        case (op)
            mips_pkg::OP_SB: return {24'd0, data[7:0]};
            mips_pkg::OP_SH: return {16'd0, data[15:0]};
            default:         return data;
        endcase
    endfunction

    task automatic model_exec(input logic [31:0] instr, output logic exp_valid,
                              output logic exp_illegal, output logic [4:0] exp_rd,
                              output logic [31:0] exp_data);
        mips_pkg::opcode_e       op;
        logic [31:0]             sum;
        logic [`DMEM_ADDR_W-1:0] idx;
        op          = mips_pkg::opcode_e'(instr[31:26]);
        exp_rd      = instr[20:16];
        sum         = model_regs[instr[25:21]] + sext16(instr[15:0]);
        idx         = sum[`DMEM_ADDR_W-1:0];
        exp_valid   = 1'b0;
        exp_illegal = 1'b0;
        exp_data    = '0;
        case (op)
            mips_pkg::OP_ADDI: begin
                exp_valid = 1'b1;
                exp_data  = sum;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH,
            mips_pkg::OP_LHU, mips_pkg::OP_LW: begin
                exp_valid = 1'b1;
                exp_data  = load_extend(op, model_mem[idx]);
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
                model_mem[idx] = store_fill(op, model_regs[exp_rd]);
            default: exp_illegal = 1'b1;
        endcase
        if (exp_valid && exp_rd != 5'd0) begin
            model_regs[exp_rd] = exp_data;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic expect_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, actual,
                     expected);
            abort_run();
        end
    endtask

    task automatic check_wb(input logic [31:0] instr,
                            input logic [`MIPS_REG_ADDR_W-1:0] exp_rd,
                            input logic [`MIPS_DATA_W-1:0] exp_data);
        if (o_wb_rd !== exp_rd || o_wb_data !== exp_data) begin
            $display("Mismatch at time %0t: instr %h wrote r%0d=%h, expected r%0d=%h",
                     $time, instr, o_wb_rd, o_wb_data, exp_rd, exp_data);
            abort_run();
        end
    endtask

    task automatic check_reg(input logic [`MIPS_REG_ADDR_W-1:0] idx);
        i_dbg_reg = idx;
        @(negedge i_clock);
        if (o_dbg_data !== model_regs[idx]) begin
            $display("Mismatch at time %0t: r%0d reads %h, expected %h", $time, idx,
                     o_dbg_data, model_regs[idx]);
            abort_run();
        end
        @(posedge i_clock);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Instruction issue
    //////////////////////////////////////////////////////////////////////
    // One instruction with the next issue slot three cycles after its strobe
    task automatic run_single(input logic [31:0] instr);
        logic        exp_valid;
        logic        exp_illegal;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        model_exec(instr, exp_valid, exp_illegal, exp_rd, exp_data);
        i_instr_valid = 1'b1;
        i_instr       = instr;
        @(posedge i_clock);
        #1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        @(negedge i_clock);
        expect_strobe("o_illegal", o_illegal, exp_illegal);
        expect_strobe("o_wb_valid", o_wb_valid, 1'b0);
        @(negedge i_clock);
        expect_strobe("o_wb_valid", o_wb_valid, exp_valid);
        expect_strobe("o_illegal", o_illegal, 1'b0);
        if (exp_valid) begin
            check_wb(instr, exp_rd, exp_data);
        end
        @(posedge i_clock);
        #1;
    endtask

    // One strobe per cycle with each result checked two cycles later
    task automatic run_burst(input logic [31:0] prog [$]);
        logic        ev [16];
        logic        ei [16];
        logic [4:0]  er [16];
        logic [31:0] ed [16];
        int          n;
        n = prog.size();
        for (int c = 0; c < n + 2; c++) begin
            if (c < n) begin
                model_exec(prog[c], ev[c], ei[c], er[c], ed[c]);
                i_instr_valid = 1'b1;
                i_instr       = prog[c];
            end else begin
                i_instr_valid = 1'b0;
                i_instr       = '0;
            end
            @(negedge i_clock);
            // Illegal pulse belongs to the previous strobe
            if (c >= 1 && c <= n) begin
                expect_strobe("o_illegal", o_illegal, ei[c-1]);
            end else begin
                expect_strobe("o_illegal", o_illegal, 1'b0);
            end
            if (c >= 2) begin
                expect_strobe("o_wb_valid", o_wb_valid, ev[c-2]);
                if (ev[c-2]) begin
                    check_wb(prog[c-2], er[c-2], ed[c-2]);
                end
            end else begin
                expect_strobe("o_wb_valid", o_wb_valid, 1'b0);
            end
            @(posedge i_clock);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic addi_constants();
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd5, 16'h1234));
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd6, 16'h8000));
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd7, 16'hffff));
        // Reported on the port but r0 keeps zero
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0055));
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd5, 5'd8, 16'hfff0));
        check_reg(5'd5);
        check_reg(5'd6);
        check_reg(5'd7);
        check_reg(5'd0);
        check_reg(5'd8);
    endtask

    task automatic word_round_trip();
        logic [31:0] rnd;
        logic [15:0] store_off;
        logic [15:0] load_off;
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0103));
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd2, 16'hbeef));
        // 0x128 and 0x108 both land on word 8
        run_single(make_instr(mips_pkg::OP_SW, 5'd1, 5'd2, 16'h0025));
        run_single(make_instr(mips_pkg::OP_LW, 5'd1, 5'd3, 16'h0005));
        for (int i = 0; i < 6; i++) begin
            rnd       = lcg_next();
            store_off = {4'd0, rnd[11:0]} - 16'h0800;
            load_off  = store_off + {9'd0, rnd[13:12], 5'd0};
            run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd2, rnd[31:16]));
            run_single(make_instr(mips_pkg::OP_SW, 5'd1, 5'd2, store_off));
            run_single(make_instr(mips_pkg::OP_LW, 5'd1, 5'd3, load_off));
        end
        check_reg(5'd3);
    endtask

    task automatic narrow_case(input logic [5:0] store_op, input logic [15:0] value,
                               input logic [15:0] off);
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd4, value));
        run_single(make_instr(store_op, 5'd1, 5'd4, off));
        run_single(make_instr(mips_pkg::OP_LB, 5'd1, 5'd20, off));
        run_single(make_instr(mips_pkg::OP_LBU, 5'd1, 5'd21, off));
        run_single(make_instr(mips_pkg::OP_LH, 5'd1, 5'd22, off));
        run_single(make_instr(mips_pkg::OP_LHU, 5'd1, 5'd23, off));
        // Shows the zero-filled upper bits
        run_single(make_instr(mips_pkg::OP_LW, 5'd1, 5'd24, off));
    endtask

    task automatic narrow_extension();
        logic [31:0] rnd;
        rnd = lcg_next();
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0040));
        narrow_case(mips_pkg::OP_SB, 16'hff85, 16'h0002);
        narrow_case(mips_pkg::OP_SB, 16'h817a, 16'h0003);
        narrow_case(mips_pkg::OP_SH, 16'h8123, 16'h0004);
        narrow_case(mips_pkg::OP_SH, rnd[15:0], 16'h0005);
    endtask

    task automatic back_to_back_issue();
        logic [31:0] prog [$];
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd9, 16'h0200));
        run_single(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd10, 16'hc3a5));
        prog.push_back(make_instr(mips_pkg::OP_SW, 5'd9, 5'd10, 16'h0003));
        prog.push_back(make_instr(mips_pkg::OP_LW, 5'd9, 5'd11, 16'h0003));
        prog.push_back(make_instr(mips_pkg::OP_ADDI, 5'd0, 5'd12, 16'h0abc));
        prog.push_back(make_instr(mips_pkg::OP_LHU, 5'd9, 5'd13, 16'h0003));
        prog.push_back(make_instr(mips_pkg::OP_ADDI, 5'd9, 5'd14, 16'h0007));
        prog.push_back(make_instr(mips_pkg::OP_SH, 5'd9, 5'd10, 16'h000c));
        prog.push_back(make_instr(mips_pkg::OP_LW, 5'd9, 5'd15, 16'h000c));
        run_burst(prog);
        for (int r = 11; r < 16; r++) begin
            check_reg(5'(r));
        end
    endtask

    task automatic illegal_opcode_ignored();
        // Store-like and ADDI-like encodings with unknown opcodes
        run_single(make_instr(6'h2a, 5'd9, 5'd12, 16'h0003));
        run_single(make_instr(6'h3f, 5'd0, 5'd16, 16'h1234));
        for (int r = 0; r < 32; r++) begin
            check_reg(5'(r));
        end
        run_single(make_instr(mips_pkg::OP_LW, 5'd9, 5'd17, 16'h0003));
    endtask

    initial begin
        i_arst_n      = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_dbg_reg     = '0;
        for (int r = 0; r < `MIPS_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge i_clock);
        #1;
        i_arst_n = 1'b1;

        addi_constants();
        word_round_trip();
        narrow_extension();
        back_to_back_issue();
        illegal_opcode_ignored();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
verilog/mips_pkg.sv
verilog/ls_decode.sv
verilog/reg_file.sv
verilog/ls_execute.sv
verilog/data_memory.sv
verilog/ls_writeback.sv
verilog/ls_unit_top.sv
tb/ls_unit_assertions.sv
tb/ls_unit_tb.sv

/* verilog/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module data_memory (
    input  wire logic                     i_clock,
    input  wire logic [`MIPS_DATA_W-1:0]  i_address,
    input  wire logic [`MIPS_DATA_W-1:0]  i_datawrite,
    input  wire logic                     i_memread,
    input  wire logic                     i_memwrite,
    input  wire logic                     i_signed,
    input  mips_pkg::mem_size_e           i_size,
    output logic      [`MIPS_DATA_W-1:0]  o_dataread
);

    logic [`MIPS_DATA_W-1:0] mem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] word_idx;
    logic [`MIPS_DATA_W-1:0] word;

    // No byte lanes, the low bits pick a whole word
    assign word_idx = i_address[`DMEM_ADDR_W-1:0];
    assign word     = mem[word_idx];

    //////////////////////////////////////////////////////////////////////
    // Read with extension by size and sign
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        o_dataread = '0;
        if (i_memread) begin
            case (i_size)
                mips_pkg::SIZE_BYTE: begin
                    if (i_signed) begin
                        o_dataread = {{(`MIPS_DATA_W-8){word[7]}}, word[7:0]};
                    end else begin
                        o_dataread = {{(`MIPS_DATA_W-8){1'b0}}, word[7:0]};
                    end
                end
                mips_pkg::SIZE_HALF: begin
                    if (i_signed) begin
                        o_dataread = {{(`MIPS_DATA_W-16){word[15]}}, word[15:0]};
                    end else begin
                        o_dataread = {{(`MIPS_DATA_W-16){1'b0}}, word[15:0]};
                    end
                end
                // Word, and any unlisted code
                default: o_dataread = word;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Clocked write
    //////////////////////////////////////////////////////////////////////
    // Narrow stores overwrite the full word, upper bits become zero
    always_ff @(posedge i_clock) begin
        if (i_memwrite) begin
            case (i_size)
                mips_pkg::SIZE_BYTE:
                    mem[word_idx] <= {{(`MIPS_DATA_W-8){1'b0}}, i_datawrite[7:0]};
                mips_pkg::SIZE_HALF:
                    mem[word_idx] <= {{(`MIPS_DATA_W-16){1'b0}}, i_datawrite[15:0]};
                default:
                    mem[word_idx] <= i_datawrite;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ls_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module ls_decode (
    input  wire logic                         i_clock,
    input  wire logic                         i_arst_n,
    input  wire logic                         i_instr_valid,
    input  wire logic [`MIPS_DATA_W-1:0]      i_instr,
    output logic                              o_valid,
    output logic                              o_is_load,
    output logic                              o_is_store,
    output logic                              o_is_addi,
    output mips_pkg::mem_size_e               o_size,
    output logic                              o_signed,
    output logic [`MIPS_REG_ADDR_W-1:0]       o_rs,
    output logic [`MIPS_REG_ADDR_W-1:0]       o_rt,
    output logic [`MIPS_DATA_W-1:0]           o_imm,
    output logic                              o_illegal
);

    mips_pkg::opcode_e   opcode;
    mips_pkg::mem_size_e dec_size;
    logic                dec_load;
    logic                dec_store;
    logic                dec_addi;
    logic                dec_signed;
    logic                dec_illegal;

    assign opcode = mips_pkg::opcode_e'(i_instr[31:26]);

    // Instruction class from the opcode field
    always_comb begin
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        dec_addi    = 1'b0;
        dec_signed  = 1'b0;
        dec_illegal = 1'b0;
        dec_size    = mips_pkg::SIZE_WORD;
        case (opcode)
            mips_pkg::OP_ADDI: dec_addi = 1'b1;
            mips_pkg::OP_LB: begin
                dec_load   = 1'b1;
                dec_size   = mips_pkg::SIZE_BYTE;
                dec_signed = 1'b1;
            end
            mips_pkg::OP_LH: begin
                dec_load   = 1'b1;
                dec_size   = mips_pkg::SIZE_HALF;
                dec_signed = 1'b1;
            end
            mips_pkg::OP_LW: dec_load = 1'b1;
            mips_pkg::OP_LBU: begin
                dec_load = 1'b1;
                dec_size = mips_pkg::SIZE_BYTE;
            end
            mips_pkg::OP_LHU: begin
                dec_load = 1'b1;
                dec_size = mips_pkg::SIZE_HALF;
            end
            mips_pkg::OP_SB: begin
                dec_store = 1'b1;
                dec_size  = mips_pkg::SIZE_BYTE;
            end
            mips_pkg::OP_SH: begin
                dec_store = 1'b1;
                dec_size  = mips_pkg::SIZE_HALF;
            end
            mips_pkg::OP_SW: dec_store = 1'b1;
            default: dec_illegal = 1'b1;
        endcase
    end

    // Control flags, an unknown opcode never becomes valid
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid    <= 1'b0;
            o_is_load  <= 1'b0;
            o_is_store <= 1'b0;
            o_is_addi  <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_valid    <= i_instr_valid && !dec_illegal;
            o_is_load  <= dec_load;
            o_is_store <= dec_store;
            o_is_addi  <= dec_addi;
            o_illegal  <= i_instr_valid && dec_illegal;
        end
    end

    // Operand fields and access attributes
    always_ff @(posedge i_clock) begin
        o_size   <= dec_size;
        o_signed <= dec_signed;
        o_rs     <= i_instr[25:21];
        o_rt     <= i_instr[20:16];
        o_imm    <= {{(`MIPS_DATA_W-16){i_instr[15]}}, i_instr[15:0]};
    end

endmodule

`default_nettype wire

/* verilog/ls_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module ls_execute (
    input  wire logic                         i_clock,
    input  wire logic                         i_arst_n,
    input  wire logic                         i_valid,
    input  wire logic                         i_is_load,
    input  wire logic                         i_is_store,
    input  wire logic                         i_is_addi,
    input  mips_pkg::mem_size_e               i_size,
    input  wire logic                         i_signed,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_rt,
    input  wire logic [`MIPS_DATA_W-1:0]      i_imm,
    input  wire logic [`MIPS_DATA_W-1:0]      i_rs_data,
    input  wire logic [`MIPS_DATA_W-1:0]      i_rt_data,
    input  wire logic [`MIPS_DATA_W-1:0]      i_dataread,
    output logic      [`MIPS_DATA_W-1:0]      o_address,
    output logic      [`MIPS_DATA_W-1:0]      o_datawrite,
    output logic                              o_memread,
    output logic                              o_memwrite,
    output logic                              o_mem_signed,
    output mips_pkg::mem_size_e               o_mem_size,
    output logic                              o_res_valid,
    output logic      [`MIPS_REG_ADDR_W-1:0]  o_res_rd,
    output logic      [`MIPS_DATA_W-1:0]      o_res_data
);

    logic [`MIPS_DATA_W-1:0] sum;

    // Same adder serves ADDI and the effective address
    assign sum = i_rs_data + i_imm;

    //////////////////////////////////////////////////////////////////////
    // Data memory request
    //////////////////////////////////////////////////////////////////////
    assign o_address    = sum;
    assign o_datawrite  = i_rt_data;
    assign o_memread    = i_valid && i_is_load;
    assign o_memwrite   = i_valid && i_is_store;
    assign o_mem_signed = i_signed;
    assign o_mem_size   = i_size;

    //////////////////////////////////////////////////////////////////////
    // Result register, stores leave no result
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_valid && (i_is_load || i_is_addi);
        end
    end

    always_ff @(posedge i_clock) begin
        o_res_rd   <= i_rt;
        o_res_data <= i_is_load ? i_dataread : sum;
    end

endmodule

`default_nettype wire

/* verilog/ls_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module ls_unit_top (
    input  wire logic                         i_clock,
    input  wire logic                         i_arst_n,
    input  wire logic                         i_instr_valid,
    input  wire logic [`MIPS_DATA_W-1:0]      i_instr,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_dbg_reg,
    output logic                              o_wb_valid,
    output logic      [`MIPS_REG_ADDR_W-1:0]  o_wb_rd,
    output logic      [`MIPS_DATA_W-1:0]      o_wb_data,
    output logic                              o_illegal,
    output logic      [`MIPS_DATA_W-1:0]      o_dbg_data
);

    // Decode to execute
    logic                        d_valid;
    logic                        d_is_load;
    logic                        d_is_store;
    logic                        d_is_addi;
    mips_pkg::mem_size_e         d_size;
    logic                        d_signed;
    logic [`MIPS_REG_ADDR_W-1:0] d_rs;
    logic [`MIPS_REG_ADDR_W-1:0] d_rt;
    logic [`MIPS_DATA_W-1:0]     d_imm;

    // Register file reads
    logic [`MIPS_DATA_W-1:0]     rs_data;
    logic [`MIPS_DATA_W-1:0]     rt_data;

    // Execute to data memory
    logic [`MIPS_DATA_W-1:0]     m_address;
    logic [`MIPS_DATA_W-1:0]     m_datawrite;
    logic                        m_memread;
    logic                        m_memwrite;
    logic                        m_signed;
    mips_pkg::mem_size_e         m_size;
    logic [`MIPS_DATA_W-1:0]     m_dataread;

    // Execute to writeback, writeback to register file
    logic                        e_valid;
    logic [`MIPS_REG_ADDR_W-1:0] e_rd;
    logic [`MIPS_DATA_W-1:0]     e_data;
    logic                        w_en;
    logic [`MIPS_REG_ADDR_W-1:0] w_addr;
    logic [`MIPS_DATA_W-1:0]     w_data;

    ls_decode u_decode (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_valid       (d_valid),
        .o_is_load     (d_is_load),
        .o_is_store    (d_is_store),
        .o_is_addi     (d_is_addi),
        .o_size        (d_size),
        .o_signed      (d_signed),
        .o_rs          (d_rs),
        .o_rt          (d_rt),
        .o_imm         (d_imm),
        .o_illegal     (o_illegal)
    );

    reg_file u_reg_file (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rs_addr  (d_rs),
        .i_rt_addr  (d_rt),
        .i_wr_en    (w_en),
        .i_wr_addr  (w_addr),
        .i_wr_data  (w_data),
        .i_dbg_addr (i_dbg_reg),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    ls_execute u_execute (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_valid      (d_valid),
        .i_is_load    (d_is_load),
        .i_is_store   (d_is_store),
        .i_is_addi    (d_is_addi),
        .i_size       (d_size),
        .i_signed     (d_signed),
        .i_rt         (d_rt),
        .i_imm        (d_imm),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .i_dataread   (m_dataread),
        .o_address    (m_address),
        .o_datawrite  (m_datawrite),
        .o_memread    (m_memread),
        .o_memwrite   (m_memwrite),
        .o_mem_signed (m_signed),
        .o_mem_size   (m_size),
        .o_res_valid  (e_valid),
        .o_res_rd     (e_rd),
        .o_res_data   (e_data)
    );

    data_memory u_data_memory (
        .i_clock     (i_clock),
        .i_address   (m_address),
        .i_datawrite (m_datawrite),
        .i_memread   (m_memread),
        .i_memwrite  (m_memwrite),
        .i_signed    (m_signed),
        .i_size      (m_size),
        .o_dataread  (m_dataread)
    );

    ls_writeback u_writeback (
        .i_res_valid (e_valid),
        .i_res_rd    (e_rd),
        .i_res_data  (e_data),
        .o_wr_en     (w_en),
        .o_wr_addr   (w_addr),
        .o_wr_data   (w_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

endmodule

`default_nettype wire

/* verilog/ls_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module ls_writeback (
    input  wire logic                         i_res_valid,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_res_rd,
    input  wire logic [`MIPS_DATA_W-1:0]      i_res_data,
    output logic                              o_wr_en,
    output logic      [`MIPS_REG_ADDR_W-1:0]  o_wr_addr,
    output logic      [`MIPS_DATA_W-1:0]      o_wr_data,
    output logic                              o_wb_valid,
    output logic      [`MIPS_REG_ADDR_W-1:0]  o_wb_rd,
    output logic      [`MIPS_DATA_W-1:0]      o_wb_data
);

    logic rd_is_zero;

    assign rd_is_zero = (i_res_rd == '0);

    // Register file port, no write when the target is r0
    assign o_wr_en   = i_res_valid && !rd_is_zero;
    assign o_wr_addr = i_res_rd;
    assign o_wr_data = i_res_data;

    // Result is still reported for r0 targets
    assign o_wb_valid = i_res_valid;
    assign o_wb_rd    = i_res_rd;
    assign o_wb_data  = i_res_data;

endmodule

`default_nettype wire

/* verilog/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcode field values of the supported I-type instructions
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_ADDI = 6'h08,
        OP_LB   = 6'h20,
        OP_LH   = 6'h21,
        OP_LW   = 6'h23,
        OP_LBU  = 6'h24,
        OP_LHU  = 6'h25,
        OP_SB   = 6'h28,
        OP_SH   = 6'h29,
        OP_SW   = 6'h2B
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // Memory access width
    //////////////////////////////////////////////////////////////////////
    // Code 0 is not listed; the memory treats it like a word
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } mem_size_e;

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module reg_file (
    input  wire logic                         i_clock,
    input  wire logic                         i_arst_n,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_rs_addr,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_rt_addr,
    input  wire logic                         i_wr_en,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_wr_addr,
    input  wire logic [`MIPS_DATA_W-1:0]      i_wr_data,
    input  wire logic [`MIPS_REG_ADDR_W-1:0]  i_dbg_addr,
    output logic      [`MIPS_DATA_W-1:0]      o_rs_data,
    output logic      [`MIPS_DATA_W-1:0]      o_rt_data,
    output logic      [`MIPS_DATA_W-1:0]      o_dbg_data
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

    // r0 is cleared by reset and never written, so it reads as zero
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Read ports
    assign o_rs_data  = regs[i_rs_addr];
    assign o_rt_data  = regs[i_rt_addr];
    assign o_dbg_data = regs[i_dbg_addr];

endmodule

`default_nettype wire
